// ==== rtl/core_pkg.sv ====
package core_pkg;

  // register width
  parameter int xlen = 64;

  // major opcodes
  parameter logic [6:0] op_imm    = 7'b0010011;
  parameter logic [6:0] op_reg    = 7'b0110011;
  parameter logic [6:0] op_lui    = 7'b0110111;
  parameter logic [6:0] op_auipc  = 7'b0010111;
  parameter logic [6:0] op_system = 7'b1110011;

  // funct3 of the supported alu ops
  parameter logic [2:0] f3_add = 3'b000;
  parameter logic [2:0] f3_xor = 3'b100;
  parameter logic [2:0] f3_or  = 3'b110;
  parameter logic [2:0] f3_and = 3'b111;

  // funct7 of sub, the only nonzero one
  parameter logic [6:0] funct7_sub = 7'b0100000;

  parameter logic [31:0] ebreak_word = 32'h0010_0073;

  // alu operation codes
  parameter logic [2:0] alu_add = 3'd0;
  parameter logic [2:0] alu_sub = 3'd1;
  parameter logic [2:0] alu_xor = 3'd2;
  parameter logic [2:0] alu_or  = 3'd3;
  parameter logic [2:0] alu_and = 3'd4;

  // apb offsets
  parameter logic [11:0] addr_imem_base = 12'h000;
  parameter logic [11:0] addr_ctrl      = 12'h400;
  parameter logic [11:0] addr_status    = 12'h404;
  parameter logic [11:0] addr_pc        = 12'h408;
  parameter logic [11:0] addr_xreg_base = 12'h800;

  // one word, two views
  // r_view top twelve bits are also the i immediate
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_view;
    struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_view;
  } inst_t;

endpackage

// ==== rtl/idu.sv ====
module idu import core_pkg::*; (
  input  logic [63:0] pc,
  input  inst_t       inst,
  input  logic [63:0] rs1_data,
  input  logic [63:0] rs2_data,
  output logic [4:0]  rs1_addr,
  output logic [4:0]  rs2_addr,
  output logic [63:0] op1,
  output logic [63:0] op2,
  output logic [2:0]  alu_op,
  output logic        rd_w_en,
  output logic [4:0]  rd_w_addr,
  output logic        inst_ebreak,
  output logic        inst_illegal
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;
  logic [2:0]      f3_alu;
  logic            f3_ok;

  // field extraction through the two views
  assign opcode = inst.r_view.opcode;
  assign funct3 = inst.r_view.funct3;
  assign funct7 = inst.r_view.funct7;

  assign rs1_addr  = inst.r_view.rs1;
  assign rs2_addr  = inst.r_view.rs2;
  assign rd_w_addr = inst.u_view.rd;

  // i imm is funct7:rs2, sign extended
  assign imm_i = {{(xlen-12){funct7[6]}}, funct7, inst.r_view.rs2};
  // u imm, shifted up 12 and sign extended from bit 31
  assign imm_u = {{(xlen-32){inst.u_view.imm20[19]}}, inst.u_view.imm20, 12'h000};

  // funct3 to alu op for the logic/add group
  always_comb begin
    f3_ok  = 1'b1;
    f3_alu = alu_add;
    case (funct3)
      f3_add:  f3_alu = alu_add;
      f3_xor:  f3_alu = alu_xor;
      f3_or:   f3_alu = alu_or;
      f3_and:  f3_alu = alu_and;
      default: f3_ok  = 1'b0;
    endcase
  end

  always_comb begin
    op1          = '0;
    op2          = '0;
    alu_op       = alu_add;
    rd_w_en      = 1'b0;
    inst_ebreak  = 1'b0;
    inst_illegal = 1'b0;
    case (opcode)
      op_imm: begin
        op1          = rs1_data;
        op2          = imm_i;
        alu_op       = f3_alu;
        rd_w_en      = f3_ok;
        inst_illegal = ~f3_ok;
      end
      op_reg: begin
        op1 = rs1_data;
        op2 = rs2_data;
        if (funct7 == 7'b0 && f3_ok) begin
          alu_op  = f3_alu;
          rd_w_en = 1'b1;
        end else if (funct7 == funct7_sub && funct3 == f3_add) begin
          alu_op  = alu_sub;
          rd_w_en = 1'b1;
        end else begin
          inst_illegal = 1'b1;
        end
      end
      // lui adds the imm to zero
      op_lui: begin
        op2     = imm_u;
        rd_w_en = 1'b1;
      end
      op_auipc: begin
        op1     = pc;
        op2     = imm_u;
        rd_w_en = 1'b1;
      end
      // only the exact ebreak word is legal here
      op_system: begin
        inst_ebreak  = (inst == ebreak_word);
        inst_illegal = (inst != ebreak_word);
      end
      default: inst_illegal = 1'b1;
    endcase
  end

endmodule

// ==== rtl/exu.sv ====
module exu import core_pkg::*; (
  input  logic [63:0] op1,
  input  logic [63:0] op2,
  input  logic [2:0]  alu_op,
  output logic [63:0] alu_result
);

  logic [xlen-1:0] sum;
  logic [xlen-1:0] diff;

  // adder and subtractor kept apart
  assign sum  = op1 + op2;
  assign diff = op1 - op2;

  always_comb begin
    case (alu_op)
      alu_add: alu_result = sum;
      alu_sub: alu_result = diff;
      alu_xor: alu_result = op1 ^ op2;
      alu_or:  alu_result = op1 | op2;
      alu_and: alu_result = op1 & op2;
      // unused codes give zero
      default: alu_result = '0;
    endcase
  end

endmodule

// ==== rtl/wbu.sv ====
module wbu import core_pkg::*; #(
  parameter int imem_depth = 64
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        run_start,
  input  logic        inst_ebreak,
  input  logic        inst_illegal,
  input  logic        rd_w_en,
  input  logic [4:0]  rd_w_addr,
  input  logic [63:0] alu_result,
  output logic [63:0] pc,
  output logic        running,
  output logic        halted,
  output logic        illegal,
  output logic        reg_we,
  output logic [4:0]  reg_waddr,
  output logic [63:0] reg_wdata
);

  // byte address of the last imem word
  localparam logic [xlen-1:0] pc_last = xlen'((imem_depth - 1) * 4);

  logic halt_now;
  logic [xlen-1:0] pc_next;

  assign halt_now = inst_ebreak | inst_illegal;
  // fetch wraps at the end of imem
  assign pc_next = (pc == pc_last) ? '0 : pc + xlen'(4);

  // no write on a halting word or to x0
  assign reg_we    = running & rd_w_en & ~halt_now & (rd_w_addr != 5'd0);
  assign reg_waddr = rd_w_addr;
  assign reg_wdata = alu_result;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc      <= '0;
      running <= 1'b0;
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else if (run_start) begin
      pc      <= '0;
      running <= 1'b1;
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else if (running) begin
      if (halt_now) begin
        // pc stays on the halting word
        running <= 1'b0;
        halted  <= 1'b1;
        illegal <= inst_illegal;
      end else begin
        pc <= pc_next;
      end
    end
  end

endmodule

// ==== rtl/regfile.sv ====
module regfile import core_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            we,
  input  logic [4:0]      waddr,
  input  logic [xlen-1:0] wdata,
  input  logic [4:0]      raddr1,
  input  logic [4:0]      raddr2,
  input  logic [4:0]      raddr3,
  output logic [xlen-1:0] rdata1,
  output logic [xlen-1:0] rdata2,
  output logic [xlen-1:0] rdata3
);

  logic [xlen-1:0] xreg [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        xreg[i] <= '0;
      end
    end else if (we && waddr != 5'd0) begin
      xreg[waddr] <= wdata;
    end
  end

  // x0 hardwired to zero on every port
  assign rdata1 = (raddr1 == 5'd0) ? '0 : xreg[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : xreg[raddr2];
  // port 3 is the apb debug view
  assign rdata3 = (raddr3 == 5'd0) ? '0 : xreg[raddr3];

endmodule

// ==== rtl/imem.sv ====
module imem import core_pkg::*; #(
  parameter int imem_depth = 64
) (
  input  logic                          clk,
  input  logic                          we,
  input  logic [$clog2(imem_depth)-1:0] waddr,
  input  logic [31:0]                   wdata,
  input  logic [$clog2(imem_depth)-1:0] raddr,
  output inst_t                         rdata
);

  logic [31:0] mem [imem_depth];

  // host loads words here
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // fetch reads straight through
  assign rdata = mem[raddr];

endmodule

// ==== rtl/apb_ctrl.sv ====
module apb_ctrl import core_pkg::*; #(
  parameter int imem_depth = 64
) (
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [11:0]                   paddr,
  input  logic [31:0]                   pwdata,
  output logic [31:0]                   prdata,
  output logic                          pready,
  output logic                          pslverr,
  input  logic                          running,
  input  logic                          halted,
  input  logic                          illegal,
  input  logic [31:0]                   pc,
  input  logic [63:0]                   dbg_data,
  output logic [4:0]                    dbg_addr,
  output logic                          imem_we,
  output logic [$clog2(imem_depth)-1:0] imem_waddr,
  output logic [31:0]                   imem_wdata,
  output logic                          run_start
);

  localparam int aw = $clog2(imem_depth);

  logic access;
  logic aligned;
  logic hit_imem;
  logic hit_ctrl;
  logic hit_status;
  logic hit_pc;
  logic hit_xreg;
  logic mapped;

  // zero wait states, done in the access cycle
  assign access = psel & penable;
  assign pready = access;

  // address window decode
  assign aligned    = (paddr[1:0] == 2'b00);
  assign hit_imem   = aligned && (paddr[11:10] == addr_imem_base[11:10]) &&
                      (int'(paddr[9:2]) < imem_depth);
  assign hit_ctrl   = (paddr == addr_ctrl);
  assign hit_status = (paddr == addr_status);
  assign hit_pc     = (paddr == addr_pc);
  // 32 regs, two halves each
  assign hit_xreg   = aligned && (paddr[11:8] == addr_xreg_base[11:8]);
  assign mapped     = hit_imem | hit_ctrl | hit_status | hit_pc | hit_xreg;

  // imem is write only from the host side
  assign pslverr = access & (~mapped | (hit_imem & ~pwrite));

  // imem load
  assign imem_we    = access & pwrite & hit_imem;
  assign imem_waddr = paddr[aw+1:2];
  assign imem_wdata = pwdata;

  // one cycle pulse, access phase is one cycle
  assign run_start = access & pwrite & hit_ctrl & pwdata[0];

  // register index, paddr[2] picks the half
  assign dbg_addr = paddr[7:3];

  always_comb begin
    prdata = 32'h0;
    if (access && !pwrite) begin
      if (hit_status) begin
        prdata = {29'h0, illegal, halted, running};
      end else if (hit_pc) begin
        prdata = pc;
      end else if (hit_xreg) begin
        prdata = paddr[2] ? dbg_data[63:32] : dbg_data[31:0];
      end
      // ctrl reads back as zero
    end
  end

endmodule

// ==== rtl/core_top.sv ====
module core_top import core_pkg::*; #(
  parameter int imem_depth = 64
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  localparam int aw = $clog2(imem_depth);

  // host side
  logic            run_start;
  logic            imem_we;
  logic [aw-1:0]   imem_waddr;
  logic [31:0]     imem_wdata;
  logic [4:0]      dbg_addr;
  logic [xlen-1:0] dbg_data;

  // datapath
  logic [xlen-1:0] pc;
  inst_t           inst;
  logic [4:0]      rs1_addr;
  logic [4:0]      rs2_addr;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic [2:0]      alu_op;
  logic [xlen-1:0] alu_result;
  logic            rd_w_en;
  logic [4:0]      rd_w_addr;
  logic            inst_ebreak;
  logic            inst_illegal;

  // writeback and state
  logic            running;
  logic            halted;
  logic            illegal;
  logic            reg_we;
  logic [4:0]      reg_waddr;
  logic [xlen-1:0] reg_wdata;

  apb_ctrl #(.imem_depth(imem_depth)) u_apb_ctrl (
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .running(running), .halted(halted), .illegal(illegal), .pc(pc[31:0]),
    .dbg_data(dbg_data), .dbg_addr(dbg_addr),
    .imem_we(imem_we), .imem_waddr(imem_waddr), .imem_wdata(imem_wdata),
    .run_start(run_start)
  );

  // fetch index is the word part of the pc
  imem #(.imem_depth(imem_depth)) u_imem (
    .clk(clk), .we(imem_we), .waddr(imem_waddr), .wdata(imem_wdata),
    .raddr(pc[aw+1:2]), .rdata(inst)
  );

  idu u_idu (
    .pc(pc), .inst(inst), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .op1(op1), .op2(op2), .alu_op(alu_op),
    .rd_w_en(rd_w_en), .rd_w_addr(rd_w_addr),
    .inst_ebreak(inst_ebreak), .inst_illegal(inst_illegal)
  );

  exu u_exu (
    .op1(op1), .op2(op2), .alu_op(alu_op), .alu_result(alu_result)
  );

  wbu #(.imem_depth(imem_depth)) u_wbu (
    .clk(clk), .rst_n(rst_n), .run_start(run_start),
    .inst_ebreak(inst_ebreak), .inst_illegal(inst_illegal),
    .rd_w_en(rd_w_en), .rd_w_addr(rd_w_addr), .alu_result(alu_result),
    .pc(pc), .running(running), .halted(halted), .illegal(illegal),
    .reg_we(reg_we), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata)
  );

  // third read port serves apb debug reads
  regfile u_regfile (
    .clk(clk), .rst_n(rst_n), .we(reg_we), .waddr(reg_waddr), .wdata(reg_wdata),
    .raddr1(rs1_addr), .raddr2(rs2_addr), .raddr3(dbg_addr),
    .rdata1(rs1_data), .rdata2(rs2_data), .rdata3(dbg_data)
  );

endmodule

// ==== testbench/tb_core_top.sv ====
module tb_core_top import core_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // random source, program image and reference registers
  logic [31:0]     lfsr_state;
  logic [31:0]     prog [$];
  logic [xlen-1:0] ref_x [32];
  // off while building words that must never execute
  logic            model_on;
  string           test_name;

  core_top #(.imem_depth(64)) u_dut (
    .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  // 20 ns period
  always #10 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      abort_run($sformatf("error %s %s expected %h actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_xreg(input string what, input logic [xlen-1:0] exp,
                            input logic [xlen-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("error %s %s expected %h actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("error %s %s expected %b actual %b", test_name, what, exp, act));
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per bit taken
  // new bit enters at the bottom
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [2:0] f3_of(input logic [1:0] sel);
    logic [2:0] f3;
    case (sel)
      2'd0:    f3 = f3_add;
      2'd1:    f3 = f3_xor;
      2'd2:    f3 = f3_or;
      default: f3 = f3_and;
    endcase
    return f3;
  endfunction

  // expected alu behavior straight from the isa rules
  function automatic logic [xlen-1:0] combine(input logic [2:0] f3, input logic sub,
                                              input logic [xlen-1:0] a,
                                              input logic [xlen-1:0] b);
    logic [xlen-1:0] r;
    case (f3)
      f3_xor:  r = a ^ b;
      f3_or:   r = a | b;
      f3_and:  r = a & b;
      default: r = sub ? a - b : a + b;
    endcase
    return r;
  endfunction

  // assemble one word and step the model with it
  task automatic put_i(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                       input logic [11:0] imm);
    logic [xlen-1:0] simm;
    simm = {{(xlen-12){imm[11]}}, imm};
    prog.push_back({imm, rs1, f3, rd, op_imm});
    if (model_on && rd != 5'd0) begin
      ref_x[rd] = combine(f3, 1'b0, ref_x[rs1], simm);
    end
  endtask

  task automatic put_r(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                       input logic [4:0] rs1, input logic [4:0] rs2);
    prog.push_back({f7, rs2, rs1, f3, rd, op_reg});
    if (model_on && rd != 5'd0) begin
      ref_x[rd] = combine(f3, f7 == funct7_sub, ref_x[rs1], ref_x[rs2]);
    end
  endtask

  // lui or auipc
  // pcv is the byte address of this word
  task automatic put_u(input logic [6:0] op, input logic [4:0] rd, input logic [19:0] imm20);
    logic [xlen-1:0] uimm;
    logic [xlen-1:0] pcv;
    uimm = {{(xlen-32){imm20[19]}}, imm20, 12'h000};
    pcv  = xlen'(prog.size() * 4);
    prog.push_back({imm20, rd, op});
    if (model_on && rd != 5'd0) begin
      ref_x[rd] = (op == op_auipc) ? pcv + uimm : uimm;
    end
  endtask

  task automatic put_word(input logic [31:0] w);
    prog.push_back(w);
  endtask

  // setup on one falling edge and access on the next
  // sampled at the rising edge that ends the access
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int waited;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    waited  = 0;
    @(posedge clk);
    while (!pready) begin
      waited++;
      if (waited > 16) begin
        abort_run($sformatf("no pready from the DUT during %s", test_name));
      end
      @(posedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused_rd;
    apb_xfer(1'b1, addr, data, unused_rd, err);
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
    apb_xfer(1'b0, addr, 32'h0, data, err);
  endtask

  task automatic wait_halted();
    logic [31:0] data;
    logic        err;
    int          polls;
    polls = 0;
    apb_read(addr_status, data, err);
    while (!data[1]) begin
      polls++;
      if (polls > 100) begin
        abort_run($sformatf("core did not halt within 100 status polls in %s", test_name));
      end
      apb_read(addr_status, data, err);
    end
  endtask

  task automatic check_all_regs();
    logic [31:0] lo;
    logic [31:0] hi;
    logic        err;
    for (int n = 0; n < 32; n++) begin
      apb_read(addr_xreg_base + 12'(8 * n), lo, err);
      check_flag("xreg pslverr", 1'b0, err);
      apb_read(addr_xreg_base + 12'(8 * n + 4), hi, err);
      check_xreg($sformatf("x%0d", n), ref_x[n], {hi, lo});
    end
  endtask

  task automatic load_program();
    logic err;
    for (int i = 0; i < prog.size(); i++) begin
      apb_write(12'(4 * i), prog[i], err);
      check_flag("imem write pslverr", 1'b0, err);
    end
  endtask

  task automatic start_run();
    logic err;
    apb_write(addr_ctrl, 32'h1, err);
    check_flag("ctrl pslverr", 1'b0, err);
  endtask

  // halted with the pc on the halting word and registers as the model says
  task automatic check_halt(input logic [31:0] exp_pc, input logic exp_ill);
    logic [31:0] data;
    logic        err;
    wait_halted();
    apb_read(addr_status, data, err);
    check_word("status", {29'h0, exp_ill, 1'b1, 1'b0}, data);
    apb_read(addr_pc, data, err);
    check_word("pc", exp_pc, data);
    check_all_regs();
  endtask

  task automatic test_reset();
    logic [31:0] data;
    logic        err;
    test_name = "reset";
    apb_read(addr_status, data, err);
    check_word("status", 32'h0, data);
    check_flag("status pslverr", 1'b0, err);
    apb_read(addr_pc, data, err);
    check_word("pc", 32'h0, data);
    check_all_regs();
    // holes in the map
    apb_read(12'h40c, data, err);
    check_flag("unmapped read pslverr", 1'b1, err);
    apb_write(12'h300, 32'h0, err);
    check_flag("unmapped write pslverr", 1'b1, err);
    // imem has no read path
    apb_read(addr_imem_base, data, err);
    check_flag("imem read pslverr", 1'b1, err);
  endtask

  task automatic test_itype();
    logic [31:0] bits;
    test_name = "itype";
    prog.delete();
    // immediate sign alternates on every word
    for (int i = 0; i < 12; i++) begin
      bits = take_bits(24);
      if (i < 4) begin
        // x1..x4 seeded from x0
        put_i(f3_add, 5'(i + 1), 5'd0, {i[0], bits[10:0]});
      end else begin
        // each of the four ops twice, sources among the seeded regs
        put_i(f3_of(2'(i % 4)), bits[21:17], {3'b000, bits[13:12]} + 5'd1,
              {i[0], bits[10:0]});
      end
    end
    put_word(ebreak_word);
    load_program();
    start_run();
    check_halt(32'((prog.size() - 1) * 4), 1'b0);
  endtask

  task automatic test_rtype();
    logic [31:0] bits;
    logic [6:0]  f7;
    test_name = "rtype";
    prog.delete();
    // x1..x8 from lui plus addi
    for (int n = 1; n <= 8; n++) begin
      bits = take_bits(32);
      put_u(op_lui, 5'(n), bits[31:12]);
      put_i(f3_add, 5'(n), 5'(n), bits[11:0]);
    end
    for (int j = 0; j < 10; j++) begin
      bits = take_bits(11);
      f7   = (j % 5 == 1) ? funct7_sub : 7'h00;
      put_r(f7, (j % 5 == 1) ? f3_add : f3_of(2'(j % 5 == 0 ? 0 : j % 5 - 1)),
            bits[10:6], {2'b00, bits[5:3]} + 5'd1, {2'b00, bits[2:0]} + 5'd1);
    end
    // writes to x0 are dropped
    put_r(7'h00, f3_add, 5'd0, 5'd1, 5'd2);
    put_i(f3_xor, 5'd0, 5'd3, 12'h5a5);
    put_word(ebreak_word);
    load_program();
    start_run();
    check_halt(32'((prog.size() - 1) * 4), 1'b0);
  endtask

  task automatic test_utype();
    logic [31:0] bits;
    test_name = "utype";
    prog.delete();
    put_i(f3_add, 5'd1, 5'd0, 12'h123);
    bits = take_bits(20);
    put_u(op_lui, 5'd21, bits[19:0] | 20'h80000);
    bits = take_bits(20);
    put_u(op_auipc, 5'd22, bits[19:0] | 20'h80000);
    bits = take_bits(20);
    put_u(op_auipc, 5'd23, bits[19:0] & 20'h7ffff);
    bits = take_bits(20);
    put_u(op_lui, 5'd24, bits[19:0] & 20'h7ffff);
    put_word(ebreak_word);
    load_program();
    start_run();
    check_halt(32'((prog.size() - 1) * 4), 1'b0);
  endtask

  task automatic test_illegal();
    logic [31:0] bits;
    logic [31:0] ill_pc;
    test_name = "illegal";
    prog.delete();
    for (int i = 0; i < 3; i++) begin
      bits = take_bits(12);
      put_i(f3_add, 5'(i + 1), 5'(i + 1), bits[11:0]);
    end
    // ld x1, 0(x0) is outside the subset
    ill_pc = 32'(prog.size() * 4);
    put_word(32'h0000_3083);
    model_on = 1'b0;
    put_i(f3_add, 5'd1, 5'd1, 12'h7ff);
    put_i(f3_or, 5'd2, 5'd0, 12'hfff);
    put_i(f3_xor, 5'd3, 5'd3, 12'h001);
    put_word(ebreak_word);
    model_on = 1'b1;
    load_program();
    start_run();
    check_halt(ill_pc, 1'b1);
  endtask

  task automatic test_rerun();
    logic [31:0] bits;
    logic [31:0] data;
    logic        err;
    test_name = "rerun";
    prog.delete();
    for (int i = 0; i < 16; i++) begin
      bits = take_bits(25);
      if (i[0]) begin
        put_r((bits[24:23] == 2'd0 && bits[22]) ? funct7_sub : 7'h00, f3_of(bits[24:23]),
              bits[21:17], bits[16:12], bits[11:7]);
      end else begin
        put_i(f3_of(bits[24:23]), bits[21:17], bits[16:12], bits[11:0]);
      end
    end
    put_word(ebreak_word);
    load_program();
    start_run();
    // halted and illegal from the last run are gone
    apb_read(addr_status, data, err);
    check_word("status after start", 32'h1, data);
    check_halt(32'((prog.size() - 1) * 4), 1'b0);
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    lfsr_state = 32'h9ed4_1c18;
    model_on   = 1'b1;
    test_name  = "init";
    for (int n = 0; n < 32; n++) begin
      ref_x[n] = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_itype();
    test_rtype();
    test_utype();
    test_illegal();
    test_rerun();
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== filelist.f ====
rtl/core_pkg.sv
rtl/idu.sv
rtl/exu.sv
rtl/wbu.sv
rtl/regfile.sv
rtl/imem.sv
rtl/apb_ctrl.sv
rtl/core_top.sv
testbench/tb_core_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run; a $fatal in the testbench gives a nonzero exit status
cd "$(dirname "$0")" &&
  verilator --binary --timing --top-module tb_core_top -f filelist.f -o tb_core_top &&
  ./obj_dir/tb_core_top || exit 1
